// ==== alu/alu_core.sv ====
// one ALU replica, computes the request and registers the response on each accepted request
`timescale 1ns/1ns

module alu_core (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 accept_i,
	input  alu_ft_pkg::alu_req_t req_i,
	input  logic                 inject_i,
	input  alu_ft_pkg::data_t    inject_data_i,
	output alu_ft_pkg::alu_rsp_t rsp_o
);

	// operands and shift amount
	alu_ft_pkg::data_t    op_a;
	alu_ft_pkg::data_t    op_b;
	alu_ft_pkg::shamt_t   shamt;

	// combinational result of this cycle's request
	alu_ft_pkg::data_t    result;
	logic                 lt_signed;
	logic                 cmp;

	// registered response, what the voter sees
	alu_ft_pkg::alu_rsp_t rsp_q;

	assign op_a  = req_i.operand_a;
	assign op_b  = req_i.operand_b;
	// only the low bits of b shift, as in RV32I
	assign shamt = op_b[alu_ft_pkg::SHAMT_W-1:0];

	assign lt_signed = $signed(op_a) < $signed(op_b);

	//////////////////////////////
	// datapath
	//////////////////////////////

	always_comb begin
		result = '0;
		case (req_i.op)
			alu_ft_pkg::ADD: result = op_a + op_b;
			alu_ft_pkg::SUB: result = op_a - op_b;
			alu_ft_pkg::AND: result = op_a & op_b;
			alu_ft_pkg::OR:  result = op_a | op_b;
			alu_ft_pkg::XOR: result = op_a ^ op_b;
			alu_ft_pkg::SLL: result = op_a << shamt;
			alu_ft_pkg::SRL: result = op_a >> shamt;
			// set-less-than gives 0 or 1 in the word
			alu_ft_pkg::SLT: result = alu_ft_pkg::data_t'(lt_signed);
			default:         result = '0;
		endcase
	end

	// comparison flag, signed less-than for slt
	// equality for every other op
	assign cmp = (req_i.op == alu_ft_pkg::SLT) ? lt_signed : (op_a == op_b);

	//////////////////////////////
	// output register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rsp_q <= '0;
		end else if (accept_i) begin
			// injected bits flip the stored result only
			rsp_q.result <= inject_i ? (result ^ inject_data_i) : result;
			rsp_q.cmp    <= cmp;
		end
	end

	// held until the next accepted request
	assign rsp_o = rsp_q;

endmodule

// ==== common/alu_ft_pkg.sv ====
// widths, operation and health encodings and request/response structs shared by the ALU block
package alu_ft_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	// datapath width of one RISC-V word
	localparam int unsigned DATA_W = 32;
	// shift amount bits taken from operand b
	localparam int unsigned SHAMT_W = $clog2(DATA_W);
	// three voted replicas plus the spare
	localparam int unsigned NUM_REPLICAS = 4;
	// inputs of the majority voter
	localparam int unsigned NUM_LANES = 3;

	//////////////////////////////
	// plain vector types
	//////////////////////////////

	typedef logic [DATA_W-1:0]       data_t;
	typedef logic [SHAMT_W-1:0]      shamt_t;
	// one bit per replica, bit 3 is the spare
	typedef logic [NUM_REPLICAS-1:0] replica_mask_t;
	// index of the replica feeding a lane
	typedef logic [1:0]              lane_idx_t;

	//////////////////////////////
	// encodings
	//////////////////////////////

	// ALU operations kept from the full execution stage ALU
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		SLL = 3'd5,
		SRL = 3'd6,
		SLT = 3'd7
	} alu_op_e;

	// replica health as tracked by the fault monitor FSM
	typedef enum logic [1:0] {
		HEALTHY = 2'd0,
		SUSPECT = 2'd1,
		FAULTY  = 2'd2
	} health_e;

	// request bundle, 67 bits
	typedef struct packed {
		alu_op_e op;
		data_t   operand_a;
		data_t   operand_b;
	} alu_req_t;

	// response bundle, 33 bits
	typedef struct packed {
		data_t result;
		logic  cmp;
	} alu_rsp_t;

endpackage

// ==== redundancy/fault_monitor.sv ====
// per-replica health FSM, counts disagreements and declares the replica permanently faulty at the threshold
`timescale 1ns/1ns

module fault_monitor #(
	parameter int unsigned FAULT_THRESHOLD = 4
) (
	input  logic clk,
	input  logic reset_i,
	input  logic update_i,
	input  logic disagree_i,
	output logic faulty_o
);

	// counter just wide enough to hold the threshold
	localparam int unsigned CNT_W = $clog2(FAULT_THRESHOLD + 1);

	typedef logic [CNT_W-1:0] err_cnt_t;

	localparam err_cnt_t THRESH_CNT = err_cnt_t'(FAULT_THRESHOLD);

	alu_ft_pkg::health_e state_q;
	alu_ft_pkg::health_e state_d;
	err_cnt_t            cnt_q;
	err_cnt_t            cnt_d;

	// a counted disagreement on this handshake
	logic                hit;

	assign hit = update_i && disagree_i;

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		case (state_q)
			alu_ft_pkg::HEALTHY: begin
				// first miss, replica becomes suspect
				if (hit) begin
					cnt_d   = cnt_q + 1'b1;
					state_d = (cnt_d == THRESH_CNT) ? alu_ft_pkg::FAULTY : alu_ft_pkg::SUSPECT;
				end
			end
			alu_ft_pkg::SUSPECT: begin
				// agreements leave the count alone
				if (hit) begin
					cnt_d   = cnt_q + 1'b1;
					state_d = (cnt_d == THRESH_CNT) ? alu_ft_pkg::FAULTY : alu_ft_pkg::SUSPECT;
				end
			end
			alu_ft_pkg::FAULTY: begin
				// permanent until reset, count saturates here
				state_d = alu_ft_pkg::FAULTY;
			end
			default: begin
				state_d = alu_ft_pkg::HEALTHY;
				cnt_d   = '0;
			end
		endcase
	end

	//////////////////////////////
	// state registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= alu_ft_pkg::HEALTHY;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
		end
	end

	// rises on the edge of the threshold-th miss
	assign faulty_o = (state_q == alu_ft_pkg::FAULTY);

endmodule

// ==== redundancy/lane_voter.sv ====
// majority voter over the three voted lanes, flags which lanes disagree and whether the error was masked
`timescale 1ns/1ns

module lane_voter (
	input  alu_ft_pkg::alu_rsp_t              lane_i [alu_ft_pkg::NUM_LANES],
	output alu_ft_pkg::alu_rsp_t              voted_o,
	output logic [alu_ft_pkg::NUM_LANES-1:0]  disagree_o,
	output logic                              err_detected_o,
	output logic                              err_corrected_o
);

	// bitwise 2-of-3 over every field
	alu_ft_pkg::alu_rsp_t maj;
	// no two lanes carry the same response
	logic                 all_differ;

	always_comb begin
		maj.result = (lane_i[0].result & lane_i[1].result)
		           | (lane_i[0].result & lane_i[2].result)
		           | (lane_i[1].result & lane_i[2].result);
		maj.cmp    = (lane_i[0].cmp & lane_i[1].cmp)
		           | (lane_i[0].cmp & lane_i[2].cmp)
		           | (lane_i[1].cmp & lane_i[2].cmp);
	end

	assign all_differ = (lane_i[0] != lane_i[1])
	                 && (lane_i[0] != lane_i[2])
	                 && (lane_i[1] != lane_i[2]);

	// three-way split, no majority exists so lane 0 wins
	assign voted_o = all_differ ? lane_i[0] : maj;

	// mark each lane that lost the vote
	always_comb begin
		for (int k = 0; k < alu_ft_pkg::NUM_LANES; k++) begin
			disagree_o[k] = (lane_i[k] != voted_o);
		end
	end

	assign err_detected_o = |disagree_o;
	// a single outvoted lane is the only correctable case
	assign err_corrected_o = err_detected_o && !all_differ;

endmodule

// ==== redundancy/spare_select.sv ====
// lane mux in front of the voter, puts the spare replica in place of the first faulty voted replica
`timescale 1ns/1ns

module spare_select (
	input  alu_ft_pkg::alu_rsp_t      rsp_i      [alu_ft_pkg::NUM_REPLICAS],
	input  alu_ft_pkg::replica_mask_t faulty_i,
	output alu_ft_pkg::alu_rsp_t      lane_o     [alu_ft_pkg::NUM_LANES],
	output alu_ft_pkg::lane_idx_t     lane_src_o [alu_ft_pkg::NUM_LANES]
);

	// spare is the last replica
	localparam alu_ft_pkg::lane_idx_t SPARE_IDX =
		alu_ft_pkg::lane_idx_t'(alu_ft_pkg::NUM_REPLICAS - 1);

	alu_ft_pkg::lane_idx_t src [alu_ft_pkg::NUM_LANES];

	//////////////////////////////
	// lane mapping
	//////////////////////////////

	// lane k normally takes replica k
	// lowest faulty voted replica hands its lane to the spare
	// only one substitution, later failures stay in place
	always_comb begin
		logic taken;
		taken = 1'b0;
		for (int k = 0; k < alu_ft_pkg::NUM_LANES; k++) begin
			src[k] = alu_ft_pkg::lane_idx_t'(k);
			if (faulty_i[k] && !taken) begin
				src[k] = SPARE_IDX;
				taken  = 1'b1;
			end
		end
	end

	// route responses and report the source of each lane
	always_comb begin
		for (int k = 0; k < alu_ft_pkg::NUM_LANES; k++) begin
			lane_o[k]     = rsp_i[src[k]];
			lane_src_o[k] = src[k];
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the fault tolerant ALU testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns \
	-f src.f \
	--top-module tb_alu_ft \
	-o sim_alu_ft

./obj_dir/sim_alu_ft | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "run_sim: simulation failed"
	exit 1
fi

echo "run_sim: simulation passed"

// ==== src.f ====
+incdir+testbench
common/alu_ft_pkg.sv
alu/alu_core.sv
redundancy/lane_voter.sv
redundancy/fault_monitor.sv
redundancy/spare_select.sv
src/alu_ft_top.sv
testbench/tb_alu_ft.sv

// ==== src/alu_ft_top.sv ====
// fault tolerant ALU top, four replicas behind a spare mux and TMR voter, valid/ready handshake
`timescale 1ns/1ns

module alu_ft_top #(
	parameter int unsigned FAULT_THRESHOLD = 4
) (
	input  logic                      clk,
	input  logic                      reset_i,
	input  logic                      req_valid_i,
	input  alu_ft_pkg::alu_req_t      req_i,
	output logic                      req_ready_o,
	output logic                      rsp_valid_o,
	output alu_ft_pkg::alu_rsp_t      rsp_o,
	input  logic                      rsp_ready_i,
	input  alu_ft_pkg::replica_mask_t inject_mask_i,
	input  alu_ft_pkg::data_t         inject_data_i,
	output logic                      err_detected_o,
	output logic                      err_corrected_o,
	output alu_ft_pkg::replica_mask_t faulty_o
);

	// handshake
	logic                                 rsp_valid_q;
	logic                                 accept;
	logic                                 consume;

	// replica and lane side
	alu_ft_pkg::alu_rsp_t                 core_rsp [alu_ft_pkg::NUM_REPLICAS];
	alu_ft_pkg::alu_rsp_t                 lane_rsp [alu_ft_pkg::NUM_LANES];
	alu_ft_pkg::lane_idx_t                lane_src [alu_ft_pkg::NUM_LANES];
	logic [alu_ft_pkg::NUM_LANES-1:0]     lane_disagree;
	alu_ft_pkg::replica_mask_t            replica_disagree;
	logic                                 vote_err_detected;
	logic                                 vote_err_corrected;

	//////////////////////////////
	// request / response handshake
	//////////////////////////////

	// one item in flight, a new request may enter as the old response leaves
	assign req_ready_o = !rsp_valid_q || rsp_ready_i;
	assign accept      = req_valid_i && req_ready_o;
	assign consume     = rsp_valid_q && rsp_ready_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rsp_valid_q <= 1'b0;
		end else if (accept) begin
			rsp_valid_q <= 1'b1;
		end else if (consume) begin
			rsp_valid_q <= 1'b0;
		end
	end

	assign rsp_valid_o = rsp_valid_q;

	//////////////////////////////
	// replicas and health
	//////////////////////////////

	for (genvar r = 0; r < alu_ft_pkg::NUM_REPLICAS; r++) begin : g_replica
		alu_core i_alu_core (
			.clk           ( clk              ),
			.reset_i       ( reset_i          ),
			.accept_i      ( accept           ),
			.req_i         ( req_i            ),
			.inject_i      ( inject_mask_i[r] ),
			.inject_data_i ( inject_data_i    ),
			.rsp_o         ( core_rsp[r]      )
		);

		// counts only on a response handshake
		fault_monitor #(
			.FAULT_THRESHOLD ( FAULT_THRESHOLD )
		) i_fault_monitor (
			.clk        ( clk                 ),
			.reset_i    ( reset_i             ),
			.update_i   ( consume             ),
			.disagree_i ( replica_disagree[r] ),
			.faulty_o   ( faulty_o[r]         )
		);
	end

	spare_select i_spare_select (
		.rsp_i      ( core_rsp ),
		.faulty_i   ( faulty_o ),
		.lane_o     ( lane_rsp ),
		.lane_src_o ( lane_src )
	);

	lane_voter i_lane_voter (
		.lane_i          ( lane_rsp           ),
		.voted_o         ( rsp_o              ),
		.disagree_o      ( lane_disagree      ),
		.err_detected_o  ( vote_err_detected  ),
		.err_corrected_o ( vote_err_corrected )
	);

	// lane misses back onto the replica feeding each lane
	// the spare only counts while it sits in a lane
	always_comb begin
		replica_disagree = '0;
		for (int k = 0; k < alu_ft_pkg::NUM_LANES; k++) begin
			replica_disagree[lane_src[k]] = replica_disagree[lane_src[k]] | lane_disagree[k];
		end
	end

	// flags belong to the held response
	assign err_detected_o  = rsp_valid_q && vote_err_detected;
	assign err_corrected_o = rsp_valid_q && vote_err_corrected;

endmodule

// ==== testbench/tb_alu_ft_ref.svh ====
// reference ALU, voter and replica health model for the ALU block testbench, included in its top module
`ifndef TB_ALU_FT_REF_SVH
`define TB_ALU_FT_REF_SVH

// expected voter outcome for one response
typedef struct packed {
	alu_ft_pkg::alu_rsp_t rsp;
	logic [2:0]           miss;
	logic                 det;
	logic                 corr;
} vote_t;

// model of the fault monitors, misses per replica
int                        miss_cnt [alu_ft_pkg::NUM_REPLICAS] = '{0, 0, 0, 0};
alu_ft_pkg::replica_mask_t faulty_m = '0;

//////////////////////////////
// ALU and voter reference
//////////////////////////////

// RV32I semantics, shifts use the low five bits of b
function automatic alu_ft_pkg::alu_rsp_t alu_ref(input alu_ft_pkg::alu_req_t req);
	alu_ft_pkg::alu_rsp_t rsp;
	logic signed [31:0]   sa;
	logic signed [31:0]   sb;
	sa = req.operand_a;
	sb = req.operand_b;
	case (req.op)
		alu_ft_pkg::ADD: rsp.result = req.operand_a + req.operand_b;
		alu_ft_pkg::SUB: rsp.result = req.operand_a - req.operand_b;
		alu_ft_pkg::AND: rsp.result = req.operand_a & req.operand_b;
		alu_ft_pkg::OR:  rsp.result = req.operand_a | req.operand_b;
		alu_ft_pkg::XOR: rsp.result = req.operand_a ^ req.operand_b;
		alu_ft_pkg::SLL: rsp.result = req.operand_a << req.operand_b[4:0];
		alu_ft_pkg::SRL: rsp.result = req.operand_a >> req.operand_b[4:0];
		alu_ft_pkg::SLT: rsp.result = (sa < sb) ? 32'd1 : 32'd0;
		default:         rsp.result = '0;
	endcase
	// slt compares signed, everything else tests equality
	rsp.cmp = (req.op == alu_ft_pkg::SLT) ? (sa < sb) : (req.operand_a == req.operand_b);
	return rsp;
endfunction

// what one replica registers, injection flips result bits only
function automatic alu_ft_pkg::alu_rsp_t replica_rsp(input alu_ft_pkg::alu_req_t req,
		input alu_ft_pkg::replica_mask_t mask, input alu_ft_pkg::data_t data,
		input logic [1:0] r);
	alu_ft_pkg::alu_rsp_t rsp;
	rsp = alu_ref(req);
	if (mask[r]) begin
		rsp.result = rsp.result ^ data;
	end
	return rsp;
endfunction

// spare takes the lane of the lowest faulty voted replica
function automatic logic [1:0] lane_source(input alu_ft_pkg::replica_mask_t faulty, input int lane);
	int first;
	first = -1;
	for (int r = 0; r < alu_ft_pkg::NUM_LANES; r++) begin
		if (faulty[r] && first < 0) begin
			first = r;
		end
	end
	return (lane == first) ? 2'd3 : lane[1:0];
endfunction

// whole-word majority, lane 0 wins a three-way split
function automatic vote_t vote_ref(input alu_ft_pkg::alu_rsp_t l0, input alu_ft_pkg::alu_rsp_t l1,
		input alu_ft_pkg::alu_rsp_t l2);
	vote_t v;
	if (l0 == l1 || l0 == l2) begin
		v.rsp = l0;
	end else if (l1 == l2) begin
		v.rsp = l1;
	end else begin
		v.rsp = l0;
	end
	v.miss = {l2 != v.rsp, l1 != v.rsp, l0 != v.rsp};
	v.det  = |v.miss;
	v.corr = ($countones(v.miss) == 1);
	return v;
endfunction

//////////////////////////////
// health model and check
//////////////////////////////

// count misses of the replica in each lane, faulty at the threshold
task automatic update_health(input logic [2:0] miss);
	alu_ft_pkg::replica_mask_t next_faulty;
	logic [1:0]                r;
	next_faulty = faulty_m;
	for (int k = 0; k < alu_ft_pkg::NUM_LANES; k++) begin
		r = lane_source(faulty_m, k);
		if (miss[k] && !faulty_m[r]) begin
			miss_cnt[r] = miss_cnt[r] + 1;
			if (miss_cnt[r] == int'(FAULT_THRESHOLD)) begin
				next_faulty[r] = 1'b1;
			end
		end
	end
	faulty_m = next_faulty;
endtask

task automatic check_equal(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
	if (expected !== actual) begin
		stop_with_failure($sformatf("Mismatch in %s: expected %0h, actual %0h",
			name, expected, actual));
	end
endtask

`endif

// ==== testbench/tb_alu_ft.sv ====
// testbench for the fault tolerant ALU, random requests with fault injection checked against a model
`timescale 1ns/1ns

module tb_alu_ft;

	localparam int unsigned FAULT_THRESHOLD = 4;
	localparam int unsigned CLK_PERIOD      = 8;
	localparam int unsigned RESET_CYCLES    = 5;
	localparam int unsigned NUM_RANDOM      = 200;
	localparam int unsigned NUM_BP          = 100;
	// directed fault requests on top of the random ones
	localparam int unsigned NUM_REQ         = NUM_RANDOM + NUM_BP + 17;
	localparam int unsigned TIMEOUT_CYCLES  = 2 * NUM_REQ + 200;

	logic                      clk = 1'b0;
	logic                      reset_i;
	logic                      req_valid_i;
	alu_ft_pkg::alu_req_t      req_i;
	logic                      req_ready_o;
	logic                      rsp_valid_o;
	alu_ft_pkg::alu_rsp_t      rsp_o;
	logic                      rsp_ready_i;
	alu_ft_pkg::replica_mask_t inject_mask_i;
	alu_ft_pkg::data_t         inject_data_i;
	logic                      err_detected_o;
	logic                      err_corrected_o;
	alu_ft_pkg::replica_mask_t faulty_o;

	// stimulus state
	int                        seed = 95253;
	logic                      bp_on;
	string                     cur_name;
	int                        issued = 0;
	int                        checked = 0;
	int                        cycle_cnt = 0;

	// requests in flight, in acceptance order
	alu_ft_pkg::alu_req_t      req_q [$];
	alu_ft_pkg::replica_mask_t mask_q [$];
	alu_ft_pkg::data_t         data_q [$];
	string                     name_q [$];

	// last held response under back-pressure
	logic                      hold_seen = 1'b0;
	alu_ft_pkg::alu_rsp_t      hold_rsp;
	logic                      hold_det;
	logic                      hold_corr;

	`include "tb_alu_ft_ref.svh"

	alu_ft_top #(
		.FAULT_THRESHOLD ( FAULT_THRESHOLD )
	) i_alu_ft_top (
		.clk             ( clk             ),
		.reset_i         ( reset_i         ),
		.req_valid_i     ( req_valid_i     ),
		.req_i           ( req_i           ),
		.req_ready_o     ( req_ready_o     ),
		.rsp_valid_o     ( rsp_valid_o     ),
		.rsp_o           ( rsp_o           ),
		.rsp_ready_i     ( rsp_ready_i     ),
		.inject_mask_i   ( inject_mask_i   ),
		.inject_data_i   ( inject_data_i   ),
		.err_detected_o  ( err_detected_o  ),
		.err_corrected_o ( err_corrected_o ),
		.faulty_o        ( faulty_o        )
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// some requests reuse a as b so equality shows up
	task automatic random_req(output alu_ft_pkg::alu_req_t req);
		alu_ft_pkg::data_t w;
		w = $random(seed);
		req.op        = alu_ft_pkg::alu_op_e'(w[2:0]);
		req.operand_a = $random(seed);
		req.operand_b = (w[7:5] == 3'd0) ? req.operand_a : $random(seed);
	endtask

	task automatic drive_ready();
		alu_ft_pkg::data_t w;
		if (bp_on) begin
			w = $random(seed);
			rsp_ready_i = w[0];
		end else begin
			rsp_ready_i = 1'b1;
		end
	endtask

	// one request, held until the DUT takes it
	task automatic send(input string name, input alu_ft_pkg::replica_mask_t mask,
			input alu_ft_pkg::data_t data);
		alu_ft_pkg::alu_req_t req;
		logic                 accepted;
		random_req(req);
		@(negedge clk);
		req_valid_i   = 1'b1;
		req_i         = req;
		inject_mask_i = mask;
		inject_data_i = data;
		cur_name      = name;
		drive_ready();
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = req_ready_o;
			if (!accepted) begin
				@(negedge clk);
				drive_ready();
			end
		end
		issued = issued + 1;
	endtask

	// keep the response just taken waiting for one cycle
	task automatic hold_response();
		@(negedge clk);
		req_valid_i = 1'b0;
		rsp_ready_i = 1'b0;
	endtask

	// stop requesting and let the last response leave
	task automatic drain();
		@(negedge clk);
		req_valid_i   = 1'b0;
		inject_mask_i = '0;
		rsp_ready_i   = 1'b1;
		while (rsp_valid_o) begin
			@(negedge clk);
		end
	endtask

	//////////////////////////////
	// scenarios
	//////////////////////////////

	initial begin
		reset_i       = 1'b1;
		req_valid_i   = 1'b0;
		req_i         = '0;
		rsp_ready_i   = 1'b0;
		inject_mask_i = '0;
		inject_data_i = '0;
		bp_on         = 1'b0;
		cur_name      = "idle";
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		for (int i = 0; i < NUM_RANDOM; i++) begin
			send("random", '0, '0);
		end

		// spare sits outside the vote until a substitution
		for (int i = 0; i < 4; i++) begin
			send("spare idle", 4'b1000, 32'h0000_8001);
		end
		drain();
		check_equal("spare idle faulty_o", 64'd0, 64'(faulty_o));

		send("single fault", 4'b0001, 32'h0010_0400);
		// majority of two corrupted lanes wins
		send("double fault", 4'b0011, 32'h8000_0002);
		// every voted lane carries the same corrupted word
		send("triple fault", 4'b0111, 32'h0300_0030);

		bp_on = 1'b1;
		for (int i = 0; i < NUM_BP; i++) begin
			// a few held responses carry a corrected error
			// replicas 0 and 2 stay one miss under the threshold
			if (i % 25 == 12) begin
				send("backpressure fault", (i < 50) ? 4'b0001 : 4'b0100, 32'h0000_0F0F);
				hold_response();
			end else begin
				send("backpressure", '0, '0);
			end
		end
		bp_on = 1'b0;
		drain();

		for (int i = 0; i < 4; i++) begin
			send("replica 1 fault", 4'b0010, 32'hA5A5_0000);
		end
		drain();
		check_equal("replica 1 faulty_o", 64'h2, 64'(faulty_o));
		// replica 1 is out of the vote, the spare now fills lane 1
		for (int i = 0; i < 2; i++) begin
			send("removed replica", 4'b0010, 32'h0000_00FF);
		end
		for (int i = 0; i < 2; i++) begin
			send("spare fault", 4'b1000, 32'h1234_0000);
		end
		for (int i = 0; i < 2; i++) begin
			send("after swap", '0, '0);
		end
		drain();

		if (checked == issued && req_q.size() == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			stop_with_failure($sformatf("request count %0d does not match response count %0d",
				issued, checked));
		end
	end

	//////////////////////////////
	// compare
	//////////////////////////////

	always @(posedge clk) begin : compare
		alu_ft_pkg::alu_req_t      req;
		alu_ft_pkg::replica_mask_t mask;
		alu_ft_pkg::data_t         data;
		string                     name;
		vote_t                     exp;
		if (!reset_i) begin
			// held response must not move until consumed
			if (hold_seen) begin
				check_equal("backpressure rsp_valid_o", 64'd1, 64'(rsp_valid_o));
				check_equal("backpressure rsp_o", 64'(hold_rsp), 64'(rsp_o));
				check_equal("backpressure err_detected_o", 64'(hold_det), 64'(err_detected_o));
				check_equal("backpressure err_corrected_o", 64'(hold_corr), 64'(err_corrected_o));
			end
			hold_seen = rsp_valid_o && !rsp_ready_i;
			if (hold_seen) begin
				check_equal("backpressure req_ready_o", 64'd0, 64'(req_ready_o));
				hold_rsp  = rsp_o;
				hold_det  = err_detected_o;
				hold_corr = err_corrected_o;
			end
			// consume first, then a request taken on the same edge
			if (rsp_valid_o && rsp_ready_i) begin
				if (req_q.size() == 0) begin
					stop_with_failure("a response arrived with no request pending");
				end else begin
					req  = req_q.pop_front();
					mask = mask_q.pop_front();
					data = data_q.pop_front();
					name = name_q.pop_front();
					exp  = vote_ref(replica_rsp(req, mask, data, lane_source(faulty_m, 0)),
						replica_rsp(req, mask, data, lane_source(faulty_m, 1)),
						replica_rsp(req, mask, data, lane_source(faulty_m, 2)));
					check_equal({name, " result"}, 64'(exp.rsp.result), 64'(rsp_o.result));
					check_equal({name, " cmp"}, 64'(exp.rsp.cmp), 64'(rsp_o.cmp));
					check_equal({name, " err_detected_o"}, 64'(exp.det), 64'(err_detected_o));
					check_equal({name, " err_corrected_o"}, 64'(exp.corr), 64'(err_corrected_o));
					check_equal({name, " faulty_o"}, 64'(faulty_m), 64'(faulty_o));
					update_health(exp.miss);
					checked = checked + 1;
				end
			end
			if (req_valid_i && req_ready_o) begin
				req_q.push_back(req_i);
				mask_q.push_back(inject_mask_i);
				data_q.push_back(inject_data_i);
				name_q.push_back(cur_name);
			end
		end
	end

	// hung handshake guard
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > int'(TIMEOUT_CYCLES)) begin
			stop_with_failure("timeout, the run did not finish within the cycle limit");
		end
	end

endmodule
